// File: histogramPeakFinder.f
source/histPkg.sv
source/binUpdateIf.sv
source/frameSequencer.sv
source/binCountRam.sv
source/peakTracker.sv
source/windowCalc.sv
source/resultQueue.sv
source/histogramPeakFinder.sv
tests/histogramPeakFinder_chk.sv
tests/histogramPeakFinder_tb.sv

// File: Makefile
TOP = histogramPeakFinder_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f histogramPeakFinder.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: tests/histogram_trace.txt
# S lines carry one coarse bin per sample in frame order
# R lines carry pixel bin count windowLow windowHigh of each expected result
S 1
S 1
S 15
S 4
S 1
S 9
S 15
S 6
R 0 1 3 0 16
R 1 15 2 47 63
S 5
S 8
S 13
S 2
S 8
S 5
S 2
S 13
R 0 8 2 24 40
R 1 2 2 0 16
S 8
S 5
S 13
S 13
S 13
S 2
S 2
S 14
R 0 8 1 24 40
R 1 13 2 44 60

// File: tests/histogramPeakFinder_tb.sv
module histogramPeakFinder_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    // DUT runs with its default sizes, 2 samples per pixel and 2 passes
    localparam int FrameSamples = Pixels * 2 * 2;
    localparam int Timeout = 400;
    localparam logic [31:0] Seed = 32'h0cf52771;

    logic                 clk;
    logic                 combin_res;
    logic                 sampleValid;
    logic [BinBits-1:0]   sampleBin;
    logic                 sampleReady;
    logic                 peakValid;
    logic                 peakReady;
    logic [PixelBits-1:0] peakPixel;
    logic [BinBits-1:0]   peakBin;
    logic [CountBits-1:0] peakCount;
    logic [FineBits-1:0]  windowLow;
    logic [FineBits-1:0]  windowHigh;

    // trace contents, consumed from the front
    int sampleQ[$];
    int expPixel[$];
    int expBin[$];
    int expCount[$];
    int expLow[$];
    int expHigh[$];

    int          errorCount;
    int          checkCount;
    logic        timedOut;
    // separate streams for input gaps and output stalls
    logic [31:0] gapSeed;
    logic [31:0] readySeed;

    histogramPeakFinder uut (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleBin(sampleBin),
        .sampleReady(sampleReady),
        .peakValid(peakValid),
        .peakReady(peakReady),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .windowLow(windowLow),
        .windowHigh(windowHigh)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] stepLcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic stopOnTimeout(input string what);
        errorCount++;
        $display("Timeout: %s did not arrive within %0d cycles", what, Timeout);
        timedOut = 1'b1;
        // main block ends the run in this time step
        @(posedge clk);
    endtask

    task automatic loadTrace();
        int    fd;
        string line;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        fd = $fopen("tests/histogram_trace.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the trace file tests/histogram_trace.txt");
            return;
        end
        // comment lines match neither form
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "S %d", a) == 1) begin
                sampleQ.push_back(a);
            end else if ($sscanf(line, "R %d %d %d %d %d", a, b, c, d, e) == 5) begin
                expPixel.push_back(a);
                expBin.push_back(b);
                expCount.push_back(c);
                expLow.push_back(d);
                expHigh.push_back(e);
            end
        end
        $fclose(fd);
        if (sampleQ.size() != 3 * FrameSamples || expPixel.size() != 3 * Pixels) begin
            errorCount++;
            $display("Trace file does not hold three frames of samples and results");
        end
    endtask

    // called at 1 ns after an edge, returns at the same phase
    task automatic sendSample(input int bin);
        int waitCycles;
        waitCycles = 0;
        sampleValid = 1'b1;
        sampleBin = BinBits'(bin);
        while (!sampleReady && waitCycles < Timeout) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (!sampleReady) begin
            stopOnTimeout("sampleReady");
        end
        // taken at this edge
        @(posedge clk);
        #1;
        sampleValid = 1'b0;
    endtask

    task automatic driveFrame(input logic allowGaps);
        int i;
        for (i = 0; i < FrameSamples; i++) begin
            sendSample(sampleQ.pop_front());
            if (allowGaps) begin
                gapSeed = stepLcg(gapSeed);
                repeat (gapSeed[31:30]) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic checkResult(input string tag, input int idx);
        string name;
        name = $sformatf("%s result %0d", tag, idx);
        checkValue({name, " pixel"}, expPixel.pop_front(), int'(peakPixel));
        checkValue({name, " bin"}, expBin.pop_front(), int'(peakBin));
        checkValue({name, " count"}, expCount.pop_front(), int'(peakCount));
        checkValue({name, " windowLow"}, expLow.pop_front(), int'(windowLow));
        checkValue({name, " windowHigh"}, expHigh.pop_front(), int'(windowHigh));
    endtask

    // random stalls on peakReady, about one cycle in four
    task automatic collectResults(input int count, input string tag);
        int got;
        int idle;
        got = 0;
        idle = 0;
        while (got < count && idle < Timeout) begin
            readySeed = stepLcg(readySeed);
            peakReady = (readySeed[31:30] != 2'b00);
            if (peakValid && peakReady) begin
                checkResult(tag, got);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(posedge clk);
            #1;
        end
        peakReady = 1'b0;
        if (got < count) begin
            stopOnTimeout("peakValid");
        end
    endtask

    task automatic runTests();
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        checkValue("reset sampleReady", 0, int'(sampleReady));
        checkValue("reset peakValid", 0, int'(peakValid));
        combin_res = 1'b1;
        // frame 1 without gaps so repeated hits arrive back to back
        fork
            driveFrame(1'b0);
            collectResults(Pixels, "frame 1");
        join
        // frames 2 and 3 pile up with the output stalled
        driveFrame(1'b1);
        driveFrame(1'b1);
        repeat (12) begin
            @(posedge clk);
            #1;
            checkValue("back-pressure sampleReady", 0, int'(sampleReady));
        end
        checkValue("back-pressure peakValid", 1, int'(peakValid));
        collectResults(Pixels, "frame 2 tie");
        collectResults(Pixels, "frame 3 fresh");
        // queue must be empty, nothing duplicated
        repeat (8) begin
            @(posedge clk);
            #1;
            checkValue("drained peakValid", 0, int'(peakValid));
        end
    endtask

    initial begin
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sampleBin = '0;
        peakReady = 1'b0;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        gapSeed = Seed;
        readySeed = stepLcg(Seed);
        loadTrace();
        fork
            begin
                if (errorCount == 0) begin
                    runTests();
                end
            end
            wait (timedOut);
        join_any
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tests/histogramPeakFinder_chk.sv
module histogramPeakFinder_chk (
    input logic                          clk,
    input logic                          combin_res,
    input logic                          sampleReady,
    input logic                          peakValid,
    input logic                          peakReady,
    input logic                          queueRoom,
    input logic [histPkg::PixelBits-1:0] peakPixel,
    input logic [histPkg::BinBits-1:0]   peakBin,
    input logic [histPkg::CountBits-1:0] peakCount,
    input logic [histPkg::FineBits-1:0]  windowLow,
    input logic [histPkg::FineBits-1:0]  windowHigh
);

    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    // pending head keeps its data until the consumer takes it
    headHeld: assert property (@(posedge clk) disable iff (!combin_res)
        peakValid && !peakReady |=> peakValid
            && $stable({peakPixel, peakBin, peakCount, windowLow, windowHigh}))
        else $error("queue head changed or vanished before peakReady");

    // window is always the full span, clamped or not
    spanWidth: assert property (@(posedge clk) disable iff (!combin_res)
        peakValid |-> (int'(windowHigh) - int'(windowLow)) == 2 * HalfSpan)
        else $error("window width differs from the full span");

    // no new frame while the queue cannot take its results
    stallFull: assert property (@(posedge clk) disable iff (!combin_res)
        peakValid && !queueRoom |-> !sampleReady)
        else $error("sampleReady high while the result queue is short of room");

endmodule

// attach to every instance of the top level
bind histogramPeakFinder histogramPeakFinder_chk uChk (
    .clk(clk),
    .combin_res(combin_res),
    .sampleReady(sampleReady),
    .peakValid(peakValid),
    .peakReady(peakReady),
    .queueRoom(queueRoom),
    .peakPixel(peakPixel),
    .peakBin(peakBin),
    .peakCount(peakCount),
    .windowLow(windowLow),
    .windowHigh(windowHigh)
);

// File: source/histogramPeakFinder.sv
module histogramPeakFinder #(
    parameter int SamplesPerPixel = 2,
    parameter int Acquisitions = 2,
    parameter int QueueDepth = 4
) (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          sampleValid,
    input  logic [histPkg::BinBits-1:0]   sampleBin,
    output logic                          sampleReady,
    output logic                          peakValid,
    input  logic                          peakReady,
    output logic [histPkg::PixelBits-1:0] peakPixel,
    output logic [histPkg::BinBits-1:0]   peakBin,
    output logic [histPkg::CountBits-1:0] peakCount,
    output logic [histPkg::FineBits-1:0]  windowLow,
    output logic [histPkg::FineBits-1:0]  windowHigh
);

    import histPkg::*;

    // sequencer to memory
    logic [PixelBits-1:0] samplePixel;
    logic                 frameLast;
    // tracker and queue status back to the sequencer
    logic                 walkBusy;
    logic                 queueRoom;
    // frame-end walk
    logic                 trkPush;
    logic [PixelBits-1:0] trkPixel;
    logic [BinBits-1:0]   trkBin;
    logic [CountBits-1:0] trkCount;
    peakResult_t          windowResult;
    peakResult_t          headResult;

    // memory to tracker
    binUpdateIf updBus ();

    frameSequencer #(
        .SamplesPerPixel(SamplesPerPixel),
        .Acquisitions(Acquisitions)
    ) uSequencer (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .walkBusy(walkBusy),
        .queueRoom(queueRoom),
        .sampleReady(sampleReady),
        .samplePixel(samplePixel),
        .frameLast(frameLast)
    );

    binCountRam uRam (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .sampleBin(sampleBin),
        .samplePixel(samplePixel),
        .frameLast(frameLast),
        .upd(updBus.source)
    );

    peakTracker uTracker (
        .clk(clk),
        .combin_res(combin_res),
        .upd(updBus.sink),
        .walkBusy(walkBusy),
        .peakPush(trkPush),
        .peakPixel(trkPixel),
        .peakBin(trkBin),
        .peakCount(trkCount)
    );

    windowCalc uWindow (
        .peakPixel(trkPixel),
        .peakBin(trkBin),
        .peakCount(trkCount),
        .result(windowResult)
    );

    resultQueue #(
        .payload_t(peakResult_t),
        .QueueDepth(QueueDepth)
    ) uQueue (
        .clk(clk),
        .combin_res(combin_res),
        .push(trkPush),
        .pushData(windowResult),
        .popReady(peakReady),
        .popValid(peakValid),
        .popData(headResult),
        .room(queueRoom)
    );

    // queue head onto the output pins
    assign peakPixel = headResult.pixel;
    assign peakBin = headResult.bin;
    assign peakCount = headResult.count;
    assign windowLow = headResult.windowLow;
    assign windowHigh = headResult.windowHigh;

endmodule

// File: source/resultQueue.sv
module resultQueue #(
    parameter type payload_t = logic [7:0],
    parameter int  QueueDepth = 4
) (
    input  logic     clk,
    input  logic     combin_res,
    input  logic     push,
    input  payload_t pushData,
    input  logic     popReady,
    output logic     popValid,
    output payload_t popData,
    output logic     room
);

    import histPkg::*;

    localparam int PtrBits = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int UsedBits = $clog2(QueueDepth + 1);

    payload_t             slots [QueueDepth];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic [UsedBits-1:0]  used;
    logic                 doPush;
    logic                 doPop;

    // wrap for depths that are not a power of two
    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        nextPtr = (ptr == PtrBits'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // head stays put until taken
    assign popValid = (used != '0);
    assign popData = slots[rdPtr];
    assign doPop = popValid && popReady;
    assign doPush = push && (used != UsedBits'(QueueDepth));
    // free space for one frame of results
    assign room = (UsedBits'(QueueDepth) - used) >= UsedBits'(Pixels);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            used <= used + UsedBits'(doPush) - UsedBits'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= pushData;
        end
    end

endmodule

// File: source/windowCalc.sv
module windowCalc (
    input  logic [histPkg::PixelBits-1:0] peakPixel,
    input  logic [histPkg::BinBits-1:0]   peakBin,
    input  logic [histPkg::CountBits-1:0] peakCount,
    output histPkg::peakResult_t          result
);

    import histPkg::*;

    // window limits at fine width
    localparam logic [FineBits-1:0] Half = FineBits'(HalfSpan);
    localparam logic [FineBits-1:0] Span = FineBits'(2 * HalfSpan);
    localparam logic [FineBits-1:0] Top = FineBits'(FineMax);

    // start of the peak bin in fine units
    logic [FineBits-1:0] centre;

    assign centre = FineBits'(peakBin) << FineShift;

    always_comb begin
        result.pixel = peakPixel;
        result.bin = peakBin;
        result.count = peakCount;
        // near zero, pin the window to the bottom
        if (centre <= Half) begin
            result.windowLow = '0;
            result.windowHigh = Span;
        // near the top, pin it to FineMax
        end else if (centre >= Top - Half) begin
            result.windowLow = Top - Span;
            result.windowHigh = Top;
        end else begin
            // centred on the peak
            result.windowLow = centre - Half;
            result.windowHigh = centre + Half;
        end
    end

endmodule

// File: source/peakTracker.sv
module peakTracker (
    input  logic                          clk,
    input  logic                          combin_res,
    binUpdateIf.sink                      upd,
    output logic                          walkBusy,
    output logic                          peakPush,
    output logic [histPkg::PixelBits-1:0] peakPixel,
    output logic [histPkg::BinBits-1:0]   peakBin,
    output logic [histPkg::CountBits-1:0] peakCount
);

    import histPkg::*;

    // running maximum and its bin, per pixel
    logic [CountBits-1:0] maxCount [Pixels];
    logic [BinBits-1:0]   maxBin [Pixels];
    // result walk over the pixels
    logic                 walkActive;
    logic [PixelBits-1:0] walkIdx;
    logic                 frameDone;
    logic                 newPeak;

    assign frameDone = upd.valid && upd.last;
    // strictly greater, ties keep the earlier bin
    assign newPeak = upd.valid && (upd.count > maxCount[upd.pixel]);

    // busy already while the last update is arriving
    assign walkBusy = walkActive || frameDone;

    // one pixel per cycle towards the window stage
    assign peakPush = walkActive;
    assign peakPixel = walkIdx;
    assign peakBin = maxBin[walkIdx];
    assign peakCount = maxCount[walkIdx];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < Pixels; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
            walkActive <= 1'b0;
            walkIdx <= '0;
        end else begin
            if (newPeak) begin
                maxCount[upd.pixel] <= upd.count;
                maxBin[upd.pixel] <= upd.bin;
            end
            // last update is absorbed above, walk starts next cycle
            if (frameDone) begin
                walkActive <= 1'b1;
                walkIdx <= '0;
            end
            if (walkActive) begin
                // entry goes out and is zeroed for the next frame
                maxCount[walkIdx] <= '0;
                maxBin[walkIdx] <= '0;
                walkIdx <= walkIdx + 1'b1;
                if (walkIdx == PixelBits'(Pixels - 1)) begin
                    walkActive <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/binCountRam.sv
module binCountRam (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          sampleValid,
    input  logic                          sampleReady,
    input  logic [histPkg::BinBits-1:0]   sampleBin,
    input  logic [histPkg::PixelBits-1:0] samplePixel,
    input  logic                          frameLast,
    binUpdateIf.source                    upd
);

    import histPkg::*;

    // counts, one word per pixel and bin
    logic [CountBits-1:0] countMem [BinsTotal];
    // word holds a count of the current frame
    logic [BinsTotal-1:0] binValid;
    logic [AddrBits-1:0]  addr;
    logic                 accept;
    logic [CountBits-1:0] oldCount;
    logic [CountBits-1:0] newCount;

    assign accept = sampleValid && sampleReady;
    assign addr = {samplePixel, sampleBin};

    // combinational read, so a hit right after a write sees the new value
    // stale words from an older frame read as zero
    assign oldCount = binValid[addr] ? countMem[addr] : '0;
    // saturating increment
    assign newCount = (oldCount == {CountBits{1'b1}}) ? oldCount : oldCount + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            upd.valid <= 1'b0;
            upd.last <= 1'b0;
        end else begin
            upd.valid <= accept;
            upd.last <= accept && frameLast;
            // whole histogram is dropped while the last update is out
            if (upd.valid && upd.last) begin
                binValid <= '0;
            end else if (accept) begin
                binValid[addr] <= 1'b1;
            end
        end
    end

    // write back and publish the new count
    always_ff @(posedge clk) begin
        if (accept) begin
            countMem[addr] <= newCount;
            upd.pixel <= samplePixel;
            upd.bin <= sampleBin;
            upd.count <= newCount;
        end
    end

endmodule

// File: source/frameSequencer.sv
module frameSequencer #(
    parameter int SamplesPerPixel = 2,
    parameter int Acquisitions = 2
) (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          sampleValid,
    input  logic                          walkBusy,
    input  logic                          queueRoom,
    output logic                          sampleReady,
    output logic [histPkg::PixelBits-1:0] samplePixel,
    output logic                          frameLast
);

    import histPkg::*;

    // counter widths, at least one bit each
    localparam int SampleBits = (SamplesPerPixel > 1) ? $clog2(SamplesPerPixel) : 1;
    localparam int AcqBits = (Acquisitions > 1) ? $clog2(Acquisitions) : 1;

    logic [SampleBits-1:0] sampleCnt;
    logic [PixelBits-1:0]  pixelCnt;
    logic [AcqBits-1:0]    acqCnt;
    logic                  accept;
    logic                  lastSample;
    logic                  lastPixel;
    logic                  lastAcq;

    assign accept = sampleValid && sampleReady;

    // wrap points of the nested counters
    assign lastSample = (sampleCnt == SampleBits'(SamplesPerPixel - 1));
    assign lastPixel = (pixelCnt == PixelBits'(Pixels - 1));
    assign lastAcq = (acqCnt == AcqBits'(Acquisitions - 1));

    // the sample on the input now closes the frame
    assign frameLast = lastSample && lastPixel && lastAcq;
    assign samplePixel = pixelCnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            sampleReady <= 1'b0;
        end else begin
            // samples inside a pixel, then pixels, then passes
            if (accept) begin
                if (lastSample) begin
                    sampleCnt <= '0;
                    if (lastPixel) begin
                        pixelCnt <= '0;
                        acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
            // stall from frame end until the results are out of the tracker
            // and the queue can take a whole frame of them
            if (accept && frameLast) begin
                sampleReady <= 1'b0;
            end else if (!sampleReady && !walkBusy && queueRoom) begin
                sampleReady <= 1'b1;
            end
        end
    end

endmodule

// File: source/binUpdateIf.sv
interface binUpdateIf;

    import histPkg::*;

    // one histogram update per accepted sample
    logic                 valid;
    logic [PixelBits-1:0] pixel;
    logic [BinBits-1:0]   bin;
    // count after the increment
    logic [CountBits-1:0] count;
    // update belongs to the last sample of the frame
    logic                 last;

    // memory side drives
    modport source (
        output valid, pixel, bin, count, last
    );

    // tracker side, no ready since it always takes the update
    modport sink (
        input valid, pixel, bin, count, last
    );

endinterface

// File: source/histPkg.sv
package histPkg;

    // coarse bin code, 16 bins per pixel
    localparam int BinBits = 4;
    localparam int Bins = 2 ** BinBits;

    // pixel index
    localparam int PixelBits = 1;
    localparam int Pixels = 2 ** PixelBits;

    // count memory holds every bin of every pixel
    localparam int BinsTotal = Pixels * Bins;
    // address is {pixel, bin}
    localparam int AddrBits = PixelBits + BinBits;

    // counts saturate at all ones
    localparam int CountBits = 8;

    // fine time units, one coarse bin spans 2**FineShift of them
    localparam int FineBits = 6;
    localparam int FineShift = FineBits - BinBits;
    localparam int FineMax = 2 ** FineBits - 1;
    // half of the search window
    localparam int HalfSpan = 2 ** (BinBits - 1);

    // one record per pixel at frame end
    typedef struct packed {
        logic [PixelBits-1:0] pixel;
        logic [BinBits-1:0]   bin;
        logic [CountBits-1:0] count;
        logic [FineBits-1:0]  windowLow;
        logic [FineBits-1:0]  windowHigh;
    } peakResult_t;

endpackage
